// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  imem_addr_t;
	typedef logic [5:0]  dmem_addr_t;

	// Opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_t;

	// Source of an execute operand
	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_t;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src;
		logic    reg_dst;
		logic    branch;
		logic    jump;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		word_t pc_plus1;
		word_t instr;
	} fd_t;

	typedef struct packed {
		ctrl_t      ctrl;
		word_t      pc_plus1;
		word_t      rs_val;
		word_t      rt_val;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		word_t      imm;
		imem_addr_t jidx;
	} dx_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     alu_res;
		word_t     store_data;
		reg_addr_t dst;
	} xm_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		word_t     alu_res;
		word_t     load_data;
		reg_addr_t dst;
	} mw_t;

endpackage

`default_nettype wire

// ==== hdl/fwd_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fwd_if;
	import mips_pkg::*;

	// Source registers of the instruction in execute
	reg_addr_t ex_rs;
	reg_addr_t ex_rt;

	// Operand selects computed by the hazard unit
	fwd_sel_t fwd_rs_sel;
	fwd_sel_t fwd_rt_sel;

	modport exe (output ex_rs, ex_rt, input fwd_rs_sel, fwd_rt_sel);
	modport haz (input ex_rs, ex_rt, output fwd_rs_sel, fwd_rt_sel);

endinterface

`default_nettype wire

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     arst_n_i,
	input  logic     hold_i,
	input  logic     flush_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// An all-zero payload is a bubble
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			q_o <= '0;
		end else if (flush_i) begin
			q_o <= '0;
		end else if (!hold_i) begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                stall_i,
	input  logic                redirect_i,
	input  mips_pkg::imem_addr_t target_i,
	input  logic                imem_we_i,
	input  mips_pkg::imem_addr_t imem_addr_i,
	input  mips_pkg::word_t     imem_data_i,
	output mips_pkg::fd_t       fd_o
);
	import mips_pkg::*;

	word_t      imem [IMEM_DEPTH];
	imem_addr_t pc;
	imem_addr_t pc_plus1;
	imem_addr_t pc_next;

	assign pc_plus1 = pc + imem_addr_t'(1);

	// Redirect wins over a load-use stall
	assign pc_next = redirect_i ? target_i :
	                 stall_i    ? pc       : pc_plus1;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// Program load port opens only while the core is in reset
	always_ff @(posedge clk) begin
		if (!arst_n_i && imem_we_i) begin
			imem[imem_addr_i] <= imem_data_i;
		end
	end

	assign fd_o.pc_plus1 = word_t'(pc_plus1);
	assign fd_o.instr    = imem[pc];

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode (
	input  logic               clk,
	input  logic               arst_n_i,
	input  mips_pkg::fd_t      fd_i,
	input  logic               wb_we_i,
	input  mips_pkg::reg_addr_t wb_dst_i,
	input  mips_pkg::word_t    wb_val_i,
	output mips_pkg::dx_t      dx_o
);
	import mips_pkg::*;

	word_t     regs [32];
	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	ctrl_t     ctrl;

	assign opcode = opcode_t'(fd_i.instr[31:26]);
	assign funct  = funct_t'(fd_i.instr[5:0]);
	assign rs     = fd_i.instr[25:21];
	assign rt     = fd_i.instr[20:16];

	// Register file, register 0 is never written
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we_i && wb_dst_i != '0) begin
			regs[wb_dst_i] <= wb_val_i;
		end
	end

	// Main controller
	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = 1'b1;
				case (funct)
					FN_ADD:  ctrl.alu_op = ALU_ADD;
					FN_SUB:  ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					// Unknown funct (including nop) becomes a bubble
					default: ctrl = '0;
				endcase
			end
			OP_ADDI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			OP_LW: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
			end
			OP_SW: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_J:    ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	assign dx_o.ctrl     = ctrl;
	assign dx_o.pc_plus1 = fd_i.pc_plus1;
	// Same-cycle writeback is bypassed to the reads
	assign dx_o.rs_val = (rs == '0) ? '0 :
	                     (wb_we_i && wb_dst_i == rs) ? wb_val_i : regs[rs];
	assign dx_o.rt_val = (rt == '0) ? '0 :
	                     (wb_we_i && wb_dst_i == rt) ? wb_val_i : regs[rt];
	assign dx_o.rs   = rs;
	assign dx_o.rt   = rt;
	assign dx_o.rd   = fd_i.instr[15:11];
	assign dx_o.imm  = {{16{fd_i.instr[15]}}, fd_i.instr[15:0]};
	assign dx_o.jidx = fd_i.instr[5:0];

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input  mips_pkg::dx_t       dx_i,
	input  logic                ex_mem_read_i,
	input  mips_pkg::reg_addr_t ex_rt_i,
	input  mips_pkg::xm_t       xm_i,
	input  mips_pkg::mw_t       mw_i,
	input  logic                redirect_i,
	fwd_if.haz                  fwd,
	output logic                stall_o,
	output logic                flush_o
);
	import mips_pkg::*;

	// Memory stage first, then writeback, register 0 never forwards
	function automatic fwd_sel_t pick_src(reg_addr_t src, xm_t xm, mw_t mw);
		if (src != '0 && xm.ctrl.reg_write && xm.dst == src) begin
			return FWD_MEM;
		end
		if (src != '0 && mw.reg_write && mw.dst == src) begin
			return FWD_WB;
		end
		return FWD_RF;
	endfunction

	assign fwd.fwd_rs_sel = pick_src(fwd.ex_rs, xm_i, mw_i);
	assign fwd.fwd_rt_sel = pick_src(fwd.ex_rt, xm_i, mw_i);

	// Load in execute feeding the instruction being decoded
	assign stall_o = ex_mem_read_i && ex_rt_i != '0 &&
	                 (ex_rt_i == dx_i.rs || ex_rt_i == dx_i.rt);

	// Squash the two younger instructions on a taken branch or jump
	assign flush_o = redirect_i;

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute (
	input  mips_pkg::dx_t        dx_i,
	input  mips_pkg::word_t      xm_val_i,
	input  mips_pkg::word_t      wb_val_i,
	fwd_if.exe                   fwd,
	output mips_pkg::xm_t        xm_o,
	output logic                 redirect_o,
	output mips_pkg::imem_addr_t target_o
);
	import mips_pkg::*;

	word_t      src_a;
	word_t      rt_fwd;
	word_t      src_b;
	word_t      result;
	logic       zero;
	imem_addr_t br_target;

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val, word_t mem_val,
	                                  word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign fwd.ex_rs = dx_i.rs;
	assign fwd.ex_rt = dx_i.rt;

	assign src_a  = fwd_mux(fwd.fwd_rs_sel, dx_i.rs_val, xm_val_i, wb_val_i);
	assign rt_fwd = fwd_mux(fwd.fwd_rt_sel, dx_i.rt_val, xm_val_i, wb_val_i);
	assign src_b  = dx_i.ctrl.alu_src ? dx_i.imm : rt_fwd;

	always_comb begin
		case (dx_i.ctrl.alu_op)
			ALU_ADD: result = src_a + src_b;
			ALU_SUB: result = src_a - src_b;
			ALU_AND: result = src_a & src_b;
			ALU_OR:  result = src_a | src_b;
			ALU_SLT: result = {31'b0, $signed(src_a) < $signed(src_b)};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

	assign xm_o.ctrl       = dx_i.ctrl;
	assign xm_o.alu_res    = result;
	// Store data already carries any forwarded value
	assign xm_o.store_data = rt_fwd;
	assign xm_o.dst        = dx_i.ctrl.reg_dst ? dx_i.rd : dx_i.rt;

	// Word-addressed PC, so the offset is added unscaled
	assign br_target  = imem_addr_t'(dx_i.pc_plus1 + dx_i.imm);
	assign redirect_o = (dx_i.ctrl.branch && zero) || dx_i.ctrl.jump;
	assign target_o   = dx_i.ctrl.jump ? dx_i.jidx : br_target;

endmodule

`default_nettype wire

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_mem (
	input  logic          clk,
	input  mips_pkg::xm_t xm_i,
	output mips_pkg::mw_t mw_o
);
	import mips_pkg::*;

	word_t      dmem [DMEM_DEPTH];
	dmem_addr_t addr;

	// ALU result is used directly as the word index
	assign addr = dmem_addr_t'(xm_i.alu_res);

	always_ff @(posedge clk) begin
		if (xm_i.ctrl.mem_write) begin
			dmem[addr] <= xm_i.store_data;
		end
	end

	assign mw_o.reg_write  = xm_i.ctrl.reg_write;
	assign mw_o.mem_to_reg = xm_i.ctrl.mem_to_reg;
	assign mw_o.alu_res    = xm_i.alu_res;
	assign mw_o.load_data  = dmem[addr];
	assign mw_o.dst        = xm_i.dst;

endmodule

`default_nettype wire

// ==== hdl/mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_core (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 imem_we_i,
	input  mips_pkg::imem_addr_t imem_addr_i,
	input  mips_pkg::word_t      imem_data_i,
	output logic                 wb_valid_o,
	output mips_pkg::reg_addr_t  wb_dst_o,
	output mips_pkg::word_t      wb_val_o
);
	import mips_pkg::*;

	fd_t        fd_d, fd_q;
	dx_t        dx_d, dx_q;
	xm_t        xm_d, xm_q;
	mw_t        mw_d, mw_q;
	logic       stall;
	logic       flush;
	logic       redirect;
	imem_addr_t target;
	word_t      wb_val;

	fwd_if fwd_bus ();

	fetch u_fetch (
		.clk(clk), .arst_n_i(arst_n_i), .stall_i(stall),
		.redirect_i(redirect), .target_i(target),
		.imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
		.fd_o(fd_d)
	);

	pipe_reg #(.payload_t(fd_t)) fd_reg (
		.clk(clk), .arst_n_i(arst_n_i), .hold_i(stall), .flush_i(flush),
		.d_i(fd_d), .q_o(fd_q)
	);

	decode u_decode (
		.clk(clk), .arst_n_i(arst_n_i), .fd_i(fd_q),
		.wb_we_i(mw_q.reg_write), .wb_dst_i(mw_q.dst), .wb_val_i(wb_val),
		.dx_o(dx_d)
	);

	// A stall turns the decoded instruction into a bubble
	pipe_reg #(.payload_t(dx_t)) dx_reg (
		.clk(clk), .arst_n_i(arst_n_i), .hold_i(1'b0), .flush_i(stall | flush),
		.d_i(dx_d), .q_o(dx_q)
	);

	hazard_unit u_hazard (
		.dx_i(dx_d), .ex_mem_read_i(dx_q.ctrl.mem_read), .ex_rt_i(dx_q.rt),
		.xm_i(xm_q), .mw_i(mw_q), .redirect_i(redirect),
		.fwd(fwd_bus.haz), .stall_o(stall), .flush_o(flush)
	);

	execute u_execute (
		.dx_i(dx_q), .xm_val_i(xm_q.alu_res), .wb_val_i(wb_val),
		.fwd(fwd_bus.exe), .xm_o(xm_d), .redirect_o(redirect), .target_o(target)
	);

	pipe_reg #(.payload_t(xm_t)) xm_reg (
		.clk(clk), .arst_n_i(arst_n_i), .hold_i(1'b0), .flush_i(1'b0),
		.d_i(xm_d), .q_o(xm_q)
	);

	data_mem u_data_mem (.clk(clk), .xm_i(xm_q), .mw_o(mw_d));

	pipe_reg #(.payload_t(mw_t)) mw_reg (
		.clk(clk), .arst_n_i(arst_n_i), .hold_i(1'b0), .flush_i(1'b0),
		.d_i(mw_d), .q_o(mw_q)
	);

	// Writeback select
	assign wb_val = mw_q.mem_to_reg ? mw_q.load_data : mw_q.alu_res;

	assign wb_valid_o = mw_q.reg_write && mw_q.dst != '0;
	assign wb_dst_o   = mw_q.dst;
	assign wb_val_o   = wb_val;

endmodule

`default_nettype wire

// ==== test/tb_mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;
	import mips_pkg::*;

	localparam int    CLK_HALF        = 20;
	localparam int    DRIVE_DELAY     = 2;
	localparam int    RESET_CYCLES    = 8;
	localparam int    CYCLES_PER_ITEM = 8;
	localparam int    DRAIN_CYCLES    = 12;
	localparam string STIM_FILE       = "test/program_stimulus.txt";

	logic       clk;
	logic       arst_n;
	logic       imem_we;
	imem_addr_t imem_addr;
	word_t      imem_data;
	logic       wb_valid;
	reg_addr_t  wb_dst;
	word_t      wb_val;

	word_t     program_words[$];
	reg_addr_t exp_dst_q[$];
	word_t     exp_val_q[$];
	int        expected_total = 0;
	int        retired_count  = 0;
	int        dst_errors     = 0;
	int        val_errors     = 0;
	int        extra_writes   = 0;
	int        file_errors    = 0;
	int        reset_len      = 0;
	int        timeout_cycles = 0;

	mips_core dut_i (
		.clk        (clk),
		.arst_n_i   (arst_n),
		.imem_we_i  (imem_we),
		.imem_addr_i(imem_addr),
		.imem_data_i(imem_data),
		.wb_valid_o (wb_valid),
		.wb_dst_o   (wb_dst),
		.wb_val_o   (wb_val)
	);

	initial clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	task automatic read_stimulus();
		int               fd;
		int               n;
		logic [7:0]       tag;
		logic [8*128-1:0] rest;
		word_t            word;
		reg_addr_t        dst;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			file_errors++;
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			case (tag)
				"#": n = $fgets(rest, fd);
				"I": begin
					n = $fscanf(fd, "%h", word);
					if (n == 1) begin
						program_words.push_back(word);
					end else begin
						$display("instruction record without a word in stimulus file");
						file_errors++;
					end
				end
				"E": begin
					n = $fscanf(fd, "%d %h", dst, word);
					if (n == 2) begin
						exp_dst_q.push_back(dst);
						exp_val_q.push_back(word);
					end else begin
						$display("expected-write record is incomplete in stimulus file");
						file_errors++;
					end
				end
				default: begin
					$display("unknown record type in stimulus file");
					file_errors++;
				end
			endcase
		end
		$fclose(fd);
		if (program_words.size() == 0 || exp_dst_q.size() == 0) begin
			$display("stimulus file holds no program or no expected writes");
			file_errors++;
		end
		if (program_words.size() > IMEM_DEPTH) begin
			$display("program does not fit in the instruction memory");
			file_errors++;
		end
		expected_total = exp_dst_q.size();
	endtask

	// One program word per cycle while the core is held in reset
	task automatic load_and_reset();
		for (int i = 0; i < reset_len; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (i < program_words.size()) begin
				imem_we   = 1'b1;
				imem_addr = imem_addr_t'(i);
				imem_data = program_words[i];
			end else begin
				imem_we = 1'b0;
			end
		end
		@(posedge clk);
		#DRIVE_DELAY;
		imem_we = 1'b0;
		arst_n  = 1'b1;
	endtask

	// Drain catches writes that retire after the last expected one
	task automatic wait_for_retirement();
		while (exp_dst_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (DRAIN_CYCLES) @(posedge clk);
	endtask

	task automatic check_dst(input string test_name, input reg_addr_t expected,
	                         input reg_addr_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: dst expected r%0d, actual r%0d", test_name, expected, actual);
			dst_errors++;
		end
	endtask

	task automatic check_val(input string test_name, input word_t expected,
	                         input word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: value expected %h, actual %h", test_name, expected, actual);
			val_errors++;
		end
	endtask

	task automatic check_retired_write();
		string test_name;
		test_name = $sformatf("retired write %0d", retired_count);
		retired_count++;
		if (exp_dst_q.size() == 0) begin
			$display("write to r%0d = %h retired when no write was expected", wb_dst, wb_val);
			extra_writes++;
		end else begin
			check_dst(test_name, exp_dst_q.pop_front(), wb_dst);
			check_val(test_name, exp_val_q.pop_front(), wb_val);
		end
	endtask

	task automatic report_and_finish(input bit timed_out);
		int total;
		total = dst_errors + val_errors + extra_writes + file_errors + int'(timed_out);
		$display("errors: dst %0d, value %0d, unexpected %0d, file %0d, timeout %0d; retired %0d of %0d",
		         dst_errors, val_errors, extra_writes, file_errors, int'(timed_out),
		         retired_count, expected_total);
		if (total == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (arst_n && wb_valid) begin
			check_retired_write();
		end
	end

	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout before all expected writes retired");
		report_and_finish(1'b1);
	end

	initial begin
		arst_n    = 1'b0;
		imem_we   = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		read_stimulus();
		if (file_errors == 0) begin
			reset_len = (program_words.size() > RESET_CYCLES) ? program_words.size()
			                                                  : RESET_CYCLES;
			timeout_cycles = reset_len + 1 + DRAIN_CYCLES +
			                 CYCLES_PER_ITEM * (program_words.size() + expected_total);
			load_and_reset();
			wait_for_retirement();
		end
		report_and_finish(1'b0);
	end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/mips_pkg.sv
hdl/fwd_if.sv
hdl/pipe_reg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/hazard_unit.sv
hdl/execute.sv
hdl/data_mem.sv
hdl/mips_core.sv
test/tb_mips_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_mips_core
output=$(./obj_dir/Vtb_mips_core)
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== test/program_stimulus.txt ====
# Records: I <instruction word, hex> and E <destination register, decimal> <value, hex>
# A # starts a comment that runs to the end of the line
I 20010006 # 0  addi r1, r0, 6
I 2002000d # 1  addi r2, r0, 13
I 00221820 # 2  add  r3, r1, r2
I 00612022 # 3  sub  r4, r3, r1
I 00622824 # 4  and  r5, r3, r2
I 00623025 # 5  or   r6, r3, r2
I 0022382a # 6  slt  r7, r1, r2
I 2008fffd # 7  addi r8, r0, -3
I 0101482a # 8  slt  r9, r8, r1
I 20000007 # 9  addi r0, r0, 7
I 00065020 # 10 add  r10, r0, r6
I 00215820 # 11 add  r11, r1, r1
I ac0b0004 # 12 sw   r11, 4(r0)
I 8c0c0004 # 13 lw   r12, 4(r0)
I 01816820 # 14 add  r13, r12, r1
I 10220002 # 15 beq  r1, r2, +2 (not taken)
I 200e0064 # 16 addi r14, r0, 100
I 11ce0002 # 17 beq  r14, r14, +2 (taken)
I 200f0001 # 18 addi r15, r0, 1 (skipped)
I 20100002 # 19 addi r16, r0, 2 (skipped)
I 2011004d # 20 addi r17, r0, 77
I 08000018 # 21 j    24
I 20120001 # 22 addi r18, r0, 1 (skipped)
I 20130002 # 23 addi r19, r0, 2 (skipped)
I 022ea022 # 24 sub  r20, r17, r14
I 08000019 # 25 j    25
I 00000000 # 26 nop
I 00000000 # 27 nop
E 1 00000006
E 2 0000000d
E 3 00000013 # forwarded from memory and writeback stages
E 4 0000000d
E 5 00000001
E 6 0000001f
E 7 00000001
E 8 fffffffd
E 9 00000001 # signed compare
E 10 0000001f # r0 reads as zero
E 11 0000000c
E 12 0000000c # load of the stored word
E 13 00000012 # load-use stall
E 14 00000064
E 17 0000004d
E 20 ffffffe9
